/* Makefile */
VERILATOR ?= verilator
TOP       ?= share_icache_tb
FILELIST  ?= share_icache.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* rtl/ar_buffer.sv */
`timescale 1ns/1ps

module ar_buffer #(
   parameter int DEPTH = 2
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          push_valid_i,
   input  logic [icache_pkg::ADDR_W-1:0] push_addr_i,
   output logic                          push_ready_o,
   output logic                          init_arvalid_o,
   output logic [icache_pkg::ADDR_W-1:0] init_araddr_o,
   input  logic                          init_arready_i
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [icache_pkg::ADDR_W-1:0] entry_q [DEPTH];
   logic [PTR_W-1:0]              wr_ptr_q;
   logic [PTR_W-1:0]              rd_ptr_q;
   logic [CNT_W-1:0]              count_q;
   logic                          push;
   logic                          pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign push_ready_o   = (count_q != CNT_W'(DEPTH));
   assign init_arvalid_o = (count_q != '0);
   assign init_araddr_o  = entry_q[rd_ptr_q];  // Head entry drives AR
   assign push           = push_valid_i & push_ready_o;
   assign pop            = init_arvalid_o & init_arready_i;

   always_ff @(posedge clk)
   begin
      if (push)
         entry_q[wr_ptr_q] <= push_addr_i;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= next_ptr(wr_ptr_q);
         if (pop)
            rd_ptr_q <= next_ptr(rd_ptr_q);
         count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
      end
   end

endmodule

/* rtl/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl #(
   parameter int  N_WAYS = icache_pkg::N_WAYS_DEF,
   parameter int  N_SETS = icache_pkg::N_SETS_DEF,
   localparam int IDX_W  = $clog2(N_SETS),
   localparam int TAG_W  = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - IDX_W
) (
   input  logic                          clk,
   input  logic                          rst_n,
   // Fetch port
   input  logic                          fetch_req_i,
   input  logic [icache_pkg::ADDR_W-1:0] fetch_addr_i,
   input  logic [icache_pkg::ID_W-1:0]   fetch_id_i,
   output logic                          fetch_grant_o,
   output logic                          fetch_r_valid_o,
   output icache_pkg::line_t             fetch_r_data_o,
   output logic [icache_pkg::ID_W-1:0]   fetch_r_id_o,
   // Tag and data RAMs
   output logic [IDX_W-1:0]              ram_addr_o,
   output logic [N_WAYS-1:0]             ram_req_o,
   output logic                          ram_we_o,
   output logic [TAG_W-1:0]              tag_wdata_o,
   input  logic [TAG_W-1:0]              tag_rdata_i [N_WAYS],
   input  icache_pkg::line_t             data_rdata_i [N_WAYS],
   output icache_pkg::line_t             line_wdata_o,
   // Refill path
   output logic                          ar_valid_o,
   output logic [icache_pkg::ADDR_W-1:0] ar_addr_o,
   input  logic                          ar_ready_i,
   input  logic                          line_valid_i,
   input  icache_pkg::line_t             line_data_i,
   output logic                          line_taken_o,
   // Flush and status
   input  logic                          flush_req_i,
   output logic                          flush_ack_o,
   output logic                          pending_o
);

   localparam int WAY_W = (N_WAYS > 1) ? $clog2(N_WAYS) : 1;

   typedef enum logic [2:0] {S_INIT, S_IDLE, S_REQ, S_WAIT, S_FLUSH} state_e;

   state_e                      state_q;
   state_e                      state_d;
   logic [N_WAYS-1:0]           valid_q [N_SETS];
   logic [WAY_W-1:0]            rr_q [N_SETS];  // Next victim per set
   logic                        cmp_valid_q;
   logic [IDX_W-1:0]            idx_q;
   logic [TAG_W-1:0]            tag_q;
   logic [icache_pkg::ID_W-1:0] id_q;
   logic [N_WAYS-1:0]           hit_vec;
   logic [WAY_W-1:0]            hit_way;
   logic                        hit;
   logic                        miss;
   logic                        accept;
   logic                        refill_done;

   // ----------------------------------------
   // Compare stage
   // ----------------------------------------
   always_comb
   begin
      hit_vec = '0;
      hit_way = '0;
      for (int w = 0; w < N_WAYS; w++)
      begin
         hit_vec[w] = valid_q[idx_q][w] & (tag_rdata_i[w] == tag_q);
         if (hit_vec[w])
            hit_way = WAY_W'(w);
      end
   end

   assign hit         = cmp_valid_q & (|hit_vec);
   assign miss        = cmp_valid_q & ~(|hit_vec);
   assign refill_done = (state_q == S_WAIT) & line_valid_i;

   // A hit keeps the pipe open, a miss closes it until the refill answers
   assign fetch_grant_o = (state_q == S_IDLE) & ~miss & ~flush_req_i;
   assign accept        = fetch_req_i & fetch_grant_o;

   assign fetch_r_valid_o = hit | refill_done;
   assign fetch_r_data_o  = refill_done ? line_data_i : data_rdata_i[hit_way];  // Way select
   assign fetch_r_id_o    = id_q;

   // ----------------------------------------
   // RAM and refill side
   // ----------------------------------------
   assign ram_addr_o   = (state_q == S_WAIT) ? idx_q
                                             : fetch_addr_i[icache_pkg::OFFSET_W +: IDX_W];
   assign ram_req_o    = refill_done ? (N_WAYS'(1) << rr_q[idx_q]) : {N_WAYS{accept}};
   assign ram_we_o     = refill_done;
   assign tag_wdata_o  = tag_q;
   assign line_wdata_o = line_data_i;

   assign ar_valid_o   = (state_q == S_REQ);
   assign ar_addr_o    = {tag_q, idx_q, {icache_pkg::OFFSET_W{1'b0}}};  // Line aligned
   assign line_taken_o = refill_done;
   assign flush_ack_o  = (state_q == S_FLUSH);
   assign pending_o    = (state_q == S_WAIT);

   always_comb
   begin
      state_d = state_q;
      unique case (state_q)
         S_INIT:
            state_d = S_IDLE;
         S_IDLE:
         begin
            if (miss)
               state_d = S_REQ;
            else if (flush_req_i)
               state_d = S_FLUSH;
         end
         S_REQ:
         begin
            if (ar_ready_i)
               state_d = S_WAIT;
         end
         S_WAIT:
         begin
            if (line_valid_i)
               state_d = S_IDLE;
         end
         default:
            state_d = S_IDLE;  // S_FLUSH lasts one cycle
      endcase
   end

   // Request held in the compare stage and through a refill
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         idx_q <= fetch_addr_i[icache_pkg::OFFSET_W +: IDX_W];
         tag_q <= fetch_addr_i[icache_pkg::ADDR_W-1 -: TAG_W];
         id_q  <= fetch_id_i;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q     <= S_INIT;
         cmp_valid_q <= 1'b0;
         valid_q     <= '{default: '0};
         rr_q        <= '{default: '0};
      end
      else
      begin
         state_q     <= state_d;
         cmp_valid_q <= accept;
         if (state_q == S_FLUSH)
            valid_q <= '{default: '0};
         else if (refill_done)
         begin
            valid_q[idx_q][rr_q[idx_q]] <= 1'b1;
            rr_q[idx_q] <= (rr_q[idx_q] == WAY_W'(N_WAYS - 1)) ? '0 : rr_q[idx_q] + 1'b1;
         end
      end
   end

endmodule

/* rtl/icache_pkg.sv */
package icache_pkg;

   // ----------------------------------------
   // Geometry and widths
   // ----------------------------------------
   localparam int ADDR_W     = 32;  // Fetch and AXI byte address
   localparam int ID_W       = 8;   // Fetch transaction ID
   localparam int LINE_W     = 128;
   localparam int AXI_DATA_W = 64;
   localparam int BEATS      = LINE_W / AXI_DATA_W;

   // Defaults for the top level
   localparam int N_WAYS_DEF = 2;
   localparam int N_SETS_DEF = 16;

   localparam int OFFSET_W   = $clog2(LINE_W / 8);  // Byte offset inside a line

   // ----------------------------------------
   // AXI read burst for one refill
   // ----------------------------------------
   localparam logic [7:0] AR_LEN        = 8'(BEATS - 1);
   localparam logic [2:0] AR_SIZE       = 3'($clog2(AXI_DATA_W / 8));  // 8 bytes per beat
   localparam logic [1:0] AR_BURST_INCR = 2'b01;

   // One fetch word is one cache line
   typedef logic [LINE_W-1:0]     line_t;
   typedef logic [AXI_DATA_W-1:0] beat_t;

endpackage

/* rtl/icache_way_ram.sv */
`timescale 1ns/1ps

module icache_way_ram #(
   parameter int  DEPTH = 16,
   parameter type T     = logic [31:0],
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
   input  logic          clk,
   input  logic [AW-1:0] addr_i,
   input  logic          req_i,
   input  logic          we_i,
   input  T              wdata_i,
   output T              rdata_o
);

   T mem_q [DEPTH];

   // Single port, read data lands one cycle after the request
   always_ff @(posedge clk)
   begin
      if (req_i)
      begin
         if (we_i)
            mem_q[addr_i] <= wdata_i;
         else
            rdata_o <= mem_q[addr_i];  // Held until the next read
      end
   end

endmodule

/* rtl/refill_combiner.sv */
`timescale 1ns/1ps

module refill_combiner (
   input  logic              clk,
   input  logic              rst_n,
   input  icache_pkg::beat_t init_rdata_i,
   input  logic              init_rlast_i,
   input  logic              init_rvalid_i,
   output logic              init_rready_o,
   input  logic              line_taken_i,
   output logic              line_valid_o,
   output icache_pkg::line_t line_data_o
);

   localparam int IDX_W = (icache_pkg::BEATS > 1) ? $clog2(icache_pkg::BEATS) : 1;

   icache_pkg::beat_t [icache_pkg::BEATS-1:0] beat_q;
   logic [IDX_W-1:0]                          beat_idx_q;
   logic                                      beat_fire;

   // Memory is stalled while an assembled line waits for the controller
   assign init_rready_o = ~line_valid_o;
   assign beat_fire     = init_rvalid_i & init_rready_o;
   assign line_data_o   = beat_q;  // First beat sits in the low half

   always_ff @(posedge clk)
   begin
      if (beat_fire)
         beat_q[beat_idx_q] <= init_rdata_i;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         beat_idx_q   <= '0;
         line_valid_o <= 1'b0;
      end
      else
      begin
         if (beat_fire)
            beat_idx_q <= init_rlast_i ? '0 : beat_idx_q + 1'b1;  // Realign on every last beat

         if (beat_fire & init_rlast_i)
            line_valid_o <= 1'b1;
         else if (line_taken_i)
            line_valid_o <= 1'b0;
      end
   end

endmodule

/* rtl/share_icache.sv */
`timescale 1ns/1ps

module share_icache #(
   parameter int N_WAYS   = icache_pkg::N_WAYS_DEF,
   parameter int N_SETS   = icache_pkg::N_SETS_DEF,
   parameter int CACHE_ID = 1
) (
   input  logic                          clk,
   input  logic                          rst_n,
   // Fetch port
   input  logic                          fetch_req_i,
   input  logic [icache_pkg::ADDR_W-1:0] fetch_addr_i,
   input  logic [icache_pkg::ID_W-1:0]   fetch_id_i,
   output logic                          fetch_grant_o,
   output logic                          fetch_r_valid_o,
   output icache_pkg::line_t             fetch_r_data_o,
   output logic [icache_pkg::ID_W-1:0]   fetch_r_id_o,
   // AXI read address
   output logic [icache_pkg::ID_W-1:0]   init_arid_o,
   output logic [icache_pkg::ADDR_W-1:0] init_araddr_o,
   output logic [7:0]                    init_arlen_o,
   output logic [2:0]                    init_arsize_o,
   output logic [1:0]                    init_arburst_o,
   output logic                          init_arvalid_o,
   input  logic                          init_arready_i,
   // AXI read data
   input  icache_pkg::beat_t             init_rdata_i,
   input  logic                          init_rlast_i,
   input  logic                          init_rvalid_i,
   output logic                          init_rready_o,
   // Flush and status
   input  logic                          ctrl_req_flush_icache_i,
   output logic                          ctrl_ack_flush_icache_o,
   output logic                          ctrl_pending_trans_icache_o
);

   localparam int IDX_W = $clog2(N_SETS);
   localparam int TAG_W = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - IDX_W;
   localparam logic [icache_pkg::ID_W-1:0] AR_ID = CACHE_ID[icache_pkg::ID_W-1:0];

   logic [IDX_W-1:0]              ram_addr;
   logic [N_WAYS-1:0]             ram_req;
   logic                          ram_we;
   logic [TAG_W-1:0]              tag_wdata;
   logic [TAG_W-1:0]              tag_rdata [N_WAYS];
   icache_pkg::line_t             data_rdata [N_WAYS];
   icache_pkg::line_t             line_wdata;
   logic                          ar_valid;
   logic                          ar_ready;
   logic [icache_pkg::ADDR_W-1:0] ar_addr;
   logic                          line_valid;
   logic                          line_taken;
   icache_pkg::line_t             line_data;

   // Every refill is the same burst shape
   assign init_arid_o    = AR_ID;
   assign init_arlen_o   = icache_pkg::AR_LEN;
   assign init_arsize_o  = icache_pkg::AR_SIZE;
   assign init_arburst_o = icache_pkg::AR_BURST_INCR;

   icache_ctrl #(
      .N_WAYS (N_WAYS),
      .N_SETS (N_SETS)
   ) ctrl_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .fetch_req_i     (fetch_req_i),
      .fetch_addr_i    (fetch_addr_i),
      .fetch_id_i      (fetch_id_i),
      .fetch_grant_o   (fetch_grant_o),
      .fetch_r_valid_o (fetch_r_valid_o),
      .fetch_r_data_o  (fetch_r_data_o),
      .fetch_r_id_o    (fetch_r_id_o),
      .ram_addr_o      (ram_addr),
      .ram_req_o       (ram_req),
      .ram_we_o        (ram_we),
      .tag_wdata_o     (tag_wdata),
      .tag_rdata_i     (tag_rdata),
      .data_rdata_i    (data_rdata),
      .line_wdata_o    (line_wdata),
      .ar_valid_o      (ar_valid),
      .ar_addr_o       (ar_addr),
      .ar_ready_i      (ar_ready),
      .line_valid_i    (line_valid),
      .line_data_i     (line_data),
      .line_taken_o    (line_taken),
      .flush_req_i     (ctrl_req_flush_icache_i),
      .flush_ack_o     (ctrl_ack_flush_icache_o),
      .pending_o       (ctrl_pending_trans_icache_o)
   );

   ar_buffer #(
      .DEPTH (2)
   ) ar_buffer_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .push_valid_i   (ar_valid),
      .push_addr_i    (ar_addr),
      .push_ready_o   (ar_ready),
      .init_arvalid_o (init_arvalid_o),
      .init_araddr_o  (init_araddr_o),
      .init_arready_i (init_arready_i)
   );

   refill_combiner combiner_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .init_rdata_i  (init_rdata_i),
      .init_rlast_i  (init_rlast_i),
      .init_rvalid_i (init_rvalid_i),
      .init_rready_o (init_rready_o),
      .line_taken_i  (line_taken),
      .line_valid_o  (line_valid),
      .line_data_o   (line_data)
   );

   // ----------------------------------------
   // One tag RAM and one data RAM per way
   // ----------------------------------------
   for (genvar g = 0; g < N_WAYS; g++)
   begin : gen_way
      icache_way_ram #(
         .DEPTH (N_SETS),
         .T     (logic [TAG_W-1:0])
      ) tag_ram_i (
         .clk     (clk),
         .addr_i  (ram_addr),
         .req_i   (ram_req[g]),
         .we_i    (ram_we),
         .wdata_i (tag_wdata),
         .rdata_o (tag_rdata[g])
      );

      icache_way_ram #(
         .DEPTH (N_SETS),
         .T     (icache_pkg::line_t)
      ) data_ram_i (
         .clk     (clk),
         .addr_i  (ram_addr),
         .req_i   (ram_req[g]),
         .we_i    (ram_we),
         .wdata_i (line_wdata),
         .rdata_o (data_rdata[g])
      );
   end

endmodule

/* share_icache.f */
rtl/icache_pkg.sv
rtl/icache_way_ram.sv
rtl/refill_combiner.sv
rtl/ar_buffer.sv
rtl/icache_ctrl.sv
rtl/share_icache.sv
verification/share_icache_properties.sv
verification/share_icache_tb.sv

/* verification/share_icache_properties.sv */
`timescale 1ns/1ps

module share_icache_properties (
   input logic                          clk,
   input logic                          rst_n,
   input logic                          fetch_req_i,
   input logic                          fetch_grant_i,
   input logic                          r_valid_i,
   input logic [icache_pkg::ID_W-1:0]   ar_id_i,
   input logic [icache_pkg::ADDR_W-1:0] ar_addr_i,
   input logic                          ar_valid_i,
   input logic                          ar_ready_i,
   input logic                          pending_i
);

   int fail_count = 0;
   int outstanding_q;  // Accepted fetches not yet answered

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         outstanding_q <= 0;
      else if (fetch_req_i && fetch_grant_i && !r_valid_i)
         outstanding_q <= outstanding_q + 1;
      else if (!(fetch_req_i && fetch_grant_i) && r_valid_i && outstanding_q != 0)
         outstanding_q <= outstanding_q - 1;
   end

   // ----------------------------------------
   // AXI read address
   // ----------------------------------------
   ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
      ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i) && $stable(ar_id_i))
   else
   begin
      $error("AR payload changed while arready was low");
      fail_count++;
   end

   ar_pending: assert property (@(posedge clk) disable iff (!rst_n)
      ar_valid_i |-> pending_i)
   else
   begin
      $error("AR valid without a pending refill");
      fail_count++;
   end

   // ----------------------------------------
   // Fetch responses
   // ----------------------------------------
   resp_has_req: assert property (@(posedge clk) disable iff (!rst_n)
      r_valid_i |-> outstanding_q > 0)
   else
   begin
      $error("Fetch response without an accepted request");
      fail_count++;
   end

   no_ar_after_hit: assert property (@(posedge clk) disable iff (!rst_n)
      r_valid_i && !pending_i |=> !ar_valid_i)
   else
   begin
      $error("AR issued right after a hit response");
      fail_count++;
   end

endmodule

/* verification/share_icache_tb.sv */
`timescale 1ns/1ps

module share_icache_tb;

   localparam int N_WAYS   = 2;
   localparam int N_SETS   = 16;  // Set index is address bits 7:4
   localparam int CACHE_ID = 3;
   localparam int N_STRESS = 8;   // Misses under back-pressure
   localparam int TIMEOUT  = (N_STRESS + 12) * 200;  // About 20 fetches, 200 cycles each at most

   logic         clk = 1'b0;
   logic         rst_n;
   logic         fetch_req_i;
   logic [31:0]  fetch_addr_i;
   logic [7:0]   fetch_id_i;
   logic         fetch_grant_o;
   logic         fetch_r_valid_o;
   logic [127:0] fetch_r_data_o;
   logic [7:0]   fetch_r_id_o;
   logic [7:0]   init_arid_o;
   logic [31:0]  init_araddr_o;
   logic [7:0]   init_arlen_o;
   logic [2:0]   init_arsize_o;
   logic [1:0]   init_arburst_o;
   logic         init_arvalid_o;
   logic         init_arready_i = 1'b0;
   logic [63:0]  init_rdata_i = '0;
   logic         init_rlast_i = 1'b0;
   logic         init_rvalid_i = 1'b0;
   logic         init_rready_o;
   logic         ctrl_req_flush_icache_i;
   logic         ctrl_ack_flush_icache_o;
   logic         ctrl_pending_trans_icache_o;

   int           errors = 0;
   int           tests_failed = 0;
   int           cycles = 0;
   int           ar_count = 0;
   logic [31:0]  last_araddr;
   logic [7:0]   last_arid;
   logic [7:0]   last_arlen;
   logic [2:0]   last_arsize;
   logic [1:0]   last_arburst;
   logic [31:0]  rd_q [$];  // Line addresses still owed R beats
   int           r_beat = 0;
   bit           r_fired = 1'b0;
   bit           line_held = 1'b0;  // Last beat of a line was taken at the previous edge
   bit           stall_en = 1'b0;
   logic [31:0]  mem_seed = 32'h52098853;
   logic [31:0]  stim_seed;

   share_icache #(
      .N_WAYS   (N_WAYS),
      .N_SETS   (N_SETS),
      .CACHE_ID (CACHE_ID)
   ) dut_i (.*);

   bind share_icache share_icache_properties props_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .fetch_req_i   (fetch_req_i),
      .fetch_grant_i (fetch_grant_o),
      .r_valid_i     (fetch_r_valid_o),
      .ar_id_i       (init_arid_o),
      .ar_addr_i     (init_araddr_o),
      .ar_valid_i    (init_arvalid_o),
      .ar_ready_i    (init_arready_i),
      .pending_i     (ctrl_pending_trans_icache_o)
   );

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= TIMEOUT)
      begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // Every 32-bit word holds its own byte address XOR A5A5_0000
   function automatic logic [127:0] expected_line(input logic [31:0] addr);
      logic [127:0] line;
      for (int w = 0; w < 4; w++)
         line[32*w +: 32] = ({addr[31:4], 4'h0} + 32'(4 * w)) ^ 32'hA5A5_0000;
      return line;
   endfunction

   function automatic logic [63:0] model_beat(input logic [31:0] line_addr, input int beat);
      logic [31:0] lo_addr;
      lo_addr = line_addr + 32'(8 * beat);
      return {(lo_addr + 32'd4) ^ 32'hA5A5_0000, lo_addr ^ 32'hA5A5_0000};
   endfunction

   // ----------------------------------------
   // AXI memory model
   // ----------------------------------------
   always @(posedge clk)
   begin
      if (line_held)
         check_true(!init_rready_o, "init_rready_o was high while an assembled line was held");
      r_fired = init_rvalid_i && init_rready_o;
      line_held = r_fired && init_rlast_i;
      if (init_arvalid_o && init_arready_i)
      begin
         ar_count++;
         last_araddr  = init_araddr_o;
         last_arid    = init_arid_o;
         last_arlen   = init_arlen_o;
         last_arsize  = init_arsize_o;
         last_arburst = init_arburst_o;
         rd_q.push_back(init_araddr_o);
      end
      if (r_fired)
      begin
         if (init_rlast_i)
         begin
            r_beat = 0;
            void'(rd_q.pop_front());
         end
         else
            r_beat++;
      end
   end

   always @(negedge clk)
   begin
      mem_seed = lcg_next(mem_seed);
      init_arready_i = !(stall_en && mem_seed[17]);
      if (!(init_rvalid_i && !r_fired))  // A beat stays up until taken
      begin
         if (rd_q.size() != 0 && !(stall_en && mem_seed[23]))
         begin
            init_rvalid_i = 1'b1;
            init_rdata_i  = model_beat(rd_q[0], r_beat);
            init_rlast_i  = (r_beat == 1);
         end
         else
            init_rvalid_i = 1'b0;
      end
   end

   // ----------------------------------------
   // Checks and stimulus
   // ----------------------------------------
   function automatic int total_errors();
      return errors + dut_i.props_i.fail_count;
   endfunction

   task automatic check_true(input bit cond, input string what);
      assert (cond)
      else
      begin
         $display("%s", what);
         errors++;
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_line(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
      assert (got === exp)
      else
      begin
         $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic do_fetch(input logic [31:0] addr, input logic [7:0] id, input bit expect_hit);
      int ar_before;
      int lat;
      ar_before = ar_count;
      @(negedge clk);
      fetch_req_i  = 1'b1;
      fetch_addr_i = addr;
      fetch_id_i   = id;
      @(posedge clk);
      while (!fetch_grant_o)
         @(posedge clk);
      @(negedge clk);
      fetch_req_i = 1'b0;
      lat = 1;
      @(posedge clk);
      while (!fetch_r_valid_o)
      begin
         @(posedge clk);
         lat++;
      end
      check_line("fetch_r_data_o", fetch_r_data_o, expected_line(addr));
      check_word("fetch_r_id_o", 32'(fetch_r_id_o), 32'(id));
      if (expect_hit)
         check_true(lat == 1, $sformatf("Hit at 0x%h answered %0d cycles after grant", addr, lat));
      else
         check_true(ctrl_pending_trans_icache_o,
                    $sformatf("No refill pending at the miss response for 0x%h", addr));
      @(negedge clk);
      if (expect_hit)
         check_true(ar_count == ar_before, $sformatf("Hit at 0x%h issued an AR", addr));
      else
      begin
         check_true(ar_count == ar_before + 1,
                    $sformatf("Miss at 0x%h issued %0d ARs", addr, ar_count - ar_before));
         check_word("init_araddr_o", last_araddr, {addr[31:4], 4'h0});
         check_word("init_arid_o", 32'(last_arid), 32'(CACHE_ID));
         check_word("init_arlen_o", 32'(last_arlen), 32'd1);
         check_word("init_arsize_o", 32'(last_arsize), 32'd3);  // 8 bytes
         check_word("init_arburst_o", 32'(last_arburst), 32'd1);  // INCR
         @(posedge clk);
         check_true(!ctrl_pending_trans_icache_o,
                    $sformatf("Refill still pending after the response for 0x%h", addr));
      end
   endtask

   // Second request is offered in the compare cycle of the first
   task automatic fetch_pair(input logic [31:0] addr_a, input logic [7:0] id_a,
                             input logic [31:0] addr_b, input logic [7:0] id_b);
      int ar_before;
      ar_before = ar_count;
      @(negedge clk);
      fetch_req_i  = 1'b1;
      fetch_addr_i = addr_a;
      fetch_id_i   = id_a;
      @(posedge clk);
      while (!fetch_grant_o)
         @(posedge clk);
      @(negedge clk);
      fetch_addr_i = addr_b;
      fetch_id_i   = id_b;
      @(posedge clk);
      check_true(fetch_grant_o, "Second hit was not granted in the first one's compare cycle");
      check_true(fetch_r_valid_o, "First hit of the pair did not answer one cycle after grant");
      check_line("fetch_r_data_o", fetch_r_data_o, expected_line(addr_a));
      check_word("fetch_r_id_o", 32'(fetch_r_id_o), 32'(id_a));
      @(negedge clk);
      fetch_req_i = 1'b0;
      @(posedge clk);
      check_true(fetch_r_valid_o, "Second hit of the pair did not answer one cycle after grant");
      check_line("fetch_r_data_o", fetch_r_data_o, expected_line(addr_b));
      check_word("fetch_r_id_o", 32'(fetch_r_id_o), 32'(id_b));
      @(negedge clk);
      check_true(ar_count == ar_before, "Pipelined hits issued an AR");
   endtask

   task automatic finish_test(input string name, input int err_mark);
      if (total_errors() == err_mark)
         $display("Test %s: passed", name);
      else
      begin
         $display("Test %s: failed", name);
         tests_failed++;
      end
   endtask

   initial
   begin
      logic [31:0] addr;
      int          err_mark;
      fetch_req_i             = 1'b0;
      fetch_addr_i            = '0;
      fetch_id_i              = '0;
      ctrl_req_flush_icache_i = 1'b0;
      rst_n                   = 1'b0;
      stim_seed               = lcg_next(32'h52098853);
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      err_mark = total_errors();
      do_fetch(32'h0000_1048, 8'h11, 1'b0);
      finish_test("cold miss", err_mark);

      err_mark = total_errors();
      do_fetch(32'h0000_1040, 8'h12, 1'b1);
      do_fetch(32'h0000_2050, 8'h13, 1'b0);
      fetch_pair(32'h0000_104C, 8'h14, 32'h0000_2058, 8'h15);
      finish_test("hit", err_mark);

      // A, B and C share set 2
      err_mark = total_errors();
      do_fetch(32'h0000_0020, 8'h21, 1'b0);
      do_fetch(32'h0000_1020, 8'h22, 1'b0);
      do_fetch(32'h0000_2020, 8'h23, 1'b0);  // Evicts A
      do_fetch(32'h0000_0024, 8'h24, 1'b0);
      do_fetch(32'h0000_2028, 8'h25, 1'b1);
      finish_test("replacement", err_mark);

      err_mark = total_errors();
      @(negedge clk);
      ctrl_req_flush_icache_i = 1'b1;
      @(posedge clk);
      while (!ctrl_ack_flush_icache_o)
         @(posedge clk);
      @(negedge clk);
      ctrl_req_flush_icache_i = 1'b0;
      do_fetch(32'h0000_2020, 8'h31, 1'b0);  // Cached before the flush
      finish_test("flush", err_mark);

      err_mark = total_errors();
      stall_en = 1'b1;
      for (int i = 0; i < N_STRESS; i++)
      begin
         stim_seed = lcg_next(stim_seed);
         addr = 32'h0100_0000 | (32'(i) << 12) | (stim_seed & 32'h0000_0FFC);
         do_fetch(addr, stim_seed[31:24], 1'b0);
      end
      stall_en = 1'b0;
      finish_test("back-pressure", err_mark);

      $display("Tests run: 5, failed: %0d, check errors: %0d, assertion failures: %0d",
               tests_failed, errors, dut_i.props_i.fail_count);
      if (total_errors() == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule
